/* rename_config.svh */
// rename core sizing
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

////////////////////////////////////////
// register counts
////////////////////////////////////////

// architectural registers seen by dispatch
`define NUM_ARCH_REG 32

// physical tags, arch set plus free pool
`define NUM_PHYS_REG 64

////////////////////////////////////////
// queues and requesters
////////////////////////////////////////

// in-flight instructions tracked for retirement
// kept below the free pool depth so the free list never drains
`define ROB_SIZE 16

// functional units competing for the broadcast bus
`define NUM_FU 5

`endif

/* rename_pkg.sv */
// rename core types
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

  ////////////////////////////////////////
  // register names
  ////////////////////////////////////////

  // architectural register index
  typedef logic [$clog2(`NUM_ARCH_REG)-1:0] arch_reg_t;

  // physical register tag
  typedef logic [$clog2(`NUM_PHYS_REG)-1:0] phys_reg_t;

  ////////////////////////////////////////
  // queue bookkeeping
  ////////////////////////////////////////

  // rob slot index
  typedef logic [$clog2(`ROB_SIZE)-1:0] rob_ptr_t;

  // rob occupancy, needs room for a full buffer
  typedef logic [$clog2(`ROB_SIZE+1)-1:0] rob_count_t;

  // one bit per completion requester
  typedef logic [`NUM_FU-1:0] fu_mask_t;

  // free list occupancy, 0 up to the whole free pool
  typedef logic [$clog2(`NUM_PHYS_REG-`NUM_ARCH_REG+1)-1:0] free_count_t;

endpackage

`default_nettype wire

/* map_table.sv */
// register map table
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module map_table
  import rename_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  // dispatch lookups
  input  wire arch_reg_t   src_a_reg,
  input  wire arch_reg_t   src_b_reg,
  input  wire arch_reg_t   dest_reg,
  // dispatch write
  input  wire              dispatch_fire,
  input  wire phys_reg_t   new_tag,
  // broadcast
  input  wire              cdb_valid,
  input  wire phys_reg_t   cdb_tag,
  // renamed operands
  output phys_reg_t        tag_a,
  output phys_reg_t        tag_b,
  output phys_reg_t        tag_old,
  output logic             ready_a,
  output logic             ready_b
);

  // current tag of each arch register
  phys_reg_t map [`NUM_ARCH_REG];

  // value-available flag per physical tag
  logic [`NUM_PHYS_REG-1:0] ready_bits;

  ////////////////////////////////////////
  // lookups
  ////////////////////////////////////////

  // reads see the mapping before this cycle's dispatch
  // so a source equal to dest gets the old tag
  assign tag_a   = map[src_a_reg];
  assign tag_b   = map[src_b_reg];
  assign tag_old = map[dest_reg];

  // bypass a tag being broadcast right now
  assign ready_a = ready_bits[tag_a] | (cdb_valid && (cdb_tag == tag_a));
  assign ready_b = ready_bits[tag_b] | (cdb_valid && (cdb_tag == tag_b));

  ////////////////////////////////////////
  // updates
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, every tag holds a value
      for (int r = 0; r < `NUM_ARCH_REG; r++) begin
        map[r] <= phys_reg_t'(r);
      end
      ready_bits <= '1;
    end else begin
      // wake the broadcast tag
      if (cdb_valid) begin
        ready_bits[cdb_tag] <= 1'b1;
      end
      // new producer, value not there yet
      // (new tag comes off the free list, never the one on the bus)
      if (dispatch_fire) begin
        map[dest_reg]       <= new_tag;
        ready_bits[new_tag] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* free_list.sv */
// physical tag free list
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module free_list
  import rename_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  // allocate on dispatch
  input  wire              pop,
  // release on retirement
  input  wire              push,
  input  wire phys_reg_t   push_tag,
  // next tag to hand out
  output phys_reg_t        head_tag
);

  // pool size is everything beyond the arch set
  localparam int FL_SIZE  = `NUM_PHYS_REG - `NUM_ARCH_REG;
  localparam int FL_PTR_W = $clog2(FL_SIZE);

  phys_reg_t           queue [FL_SIZE];
  logic [FL_PTR_W-1:0] head;
  logic [FL_PTR_W-1:0] tail;
  free_count_t         count;

  // oldest free tag
  assign head_tag = queue[head];

  ////////////////////////////////////////
  // circular queue
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the arch set, ascending
      for (int i = 0; i < FL_SIZE; i++) begin
        queue[i] <= phys_reg_t'(`NUM_ARCH_REG + i);
      end
      head  <= '0;
      // full queue, tail wrapped onto head
      tail  <= '0;
      count <= free_count_t'(FL_SIZE);
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (push) begin
        queue[tail] <= push_tag;
        tail        <= tail + 1'b1;
      end
      // push and pop together leave count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // rob depth below pool size keeps this from draining
  a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
    pop |-> (count != '0))
    else $error("free list popped while empty");

  // only retired old tags come back, never more than were taken
  a_no_push_full: assert property (@(posedge clock) disable iff (reset)
    push |-> (count != free_count_t'(FL_SIZE)))
    else $error("free list pushed while full");

endmodule

`default_nettype wire

/* reorder_buffer.sv */
// reorder buffer
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module reorder_buffer
  import rename_pkg::*;
(
  input  wire              clock,
  input  wire              reset,
  // append at tail
  input  wire              dispatch_fire,
  input  wire arch_reg_t   dest_reg,
  input  wire phys_reg_t   new_tag,
  input  wire phys_reg_t   old_tag,
  // completion broadcast
  input  wire              cdb_valid,
  input  wire phys_reg_t   cdb_tag,
  // status and retirement
  output logic             full,
  output logic             retire_valid,
  output arch_reg_t        retire_reg,
  output phys_reg_t        retire_tag,
  output phys_reg_t        retire_tag_old
);

  // per-entry payload
  arch_reg_t entry_reg     [`ROB_SIZE];
  phys_reg_t entry_tag     [`ROB_SIZE];
  phys_reg_t entry_tag_old [`ROB_SIZE];

  // per-entry control
  logic [`ROB_SIZE-1:0] entry_valid;
  logic [`ROB_SIZE-1:0] entry_done;

  rob_ptr_t   head;
  rob_ptr_t   tail;
  rob_count_t count;

  ////////////////////////////////////////
  // status
  ////////////////////////////////////////

  assign full = (count == rob_count_t'(`ROB_SIZE));

  // oldest entry leaves once its result is in
  assign retire_valid   = entry_valid[head] & entry_done[head];
  assign retire_reg     = entry_reg[head];
  assign retire_tag     = entry_tag[head];
  assign retire_tag_old = entry_tag_old[head];

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      entry_reg[tail]     <= dest_reg;
      entry_tag[tail]     <= new_tag;
      entry_tag_old[tail] <= old_tag;
    end
  end

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
      entry_done  <= '0;
      head        <= '0;
      tail        <= '0;
      count       <= '0;
    end else begin
      // tag match against every live entry
      // at most one can hold a given tag
      if (cdb_valid) begin
        for (int i = 0; i < `ROB_SIZE; i++) begin
          if (entry_valid[i] && (entry_tag[i] == cdb_tag)) begin
            entry_done[i] <= 1'b1;
          end
        end
      end
      // retire head
      if (retire_valid) begin
        entry_valid[head] <= 1'b0;
        head              <= head + 1'b1;
      end
      // new entry starts incomplete, overrides any stale mark above
      if (dispatch_fire) begin
        entry_valid[tail] <= 1'b1;
        entry_done[tail]  <= 1'b0;
        tail              <= tail + 1'b1;
      end
      case ({dispatch_fire, retire_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // top level must hold dispatch off while full
  a_no_dispatch_full: assert property (@(posedge clock) disable iff (reset)
    dispatch_fire |-> !full)
    else $error("dispatch into a full reorder buffer");

endmodule

`default_nettype wire

/* complete_select.sv */
// completion select and CDB
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module complete_select
  import rename_pkg::*;
(
  input  wire                          clock,
  input  wire                          reset,
  // requests held until granted
  input  wire fu_mask_t                fu_request,
  input  wire phys_reg_t [`NUM_FU-1:0] fu_tag,
  // grant and broadcast
  output fu_mask_t                     fu_grant,
  output logic                         cdb_valid,
  output phys_reg_t                    cdb_tag
);

  // tag of the winning unit
  phys_reg_t sel_tag;

  ////////////////////////////////////////
  // fixed priority, lowest index wins
  ////////////////////////////////////////

  always_comb begin
    fu_grant = '0;
    sel_tag  = '0;
    // scan downward so a lower requester overwrites a higher one
    for (int i = `NUM_FU - 1; i >= 0; i--) begin
      if (fu_request[i]) begin
        fu_grant = fu_mask_t'(1 << i);
        sel_tag  = fu_tag[i];
      end
    end
  end

  ////////////////////////////////////////
  // registered broadcast
  ////////////////////////////////////////

  // one cycle per grant, unit drops its request after the edge
  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= |fu_request;
    end
  end

  always_ff @(posedge clock) begin
    if (|fu_request) begin
      cdb_tag <= sel_tag;
    end
  end

  a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
    $onehot0(fu_grant))
    else $error("more than one unit granted");

  a_grant_requested: assert property (@(posedge clock) disable iff (reset)
    (fu_grant & ~fu_request) == '0)
    else $error("grant to a unit with no request");

endmodule

`default_nettype wire

/* rename_core.sv */
// rename and retire core
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_core
  import rename_pkg::*;
(
  input  wire                          clock,
  input  wire                          reset,
  // dispatch request
  input  wire                          dispatch_valid,
  input  wire arch_reg_t               dest_reg,
  input  wire arch_reg_t               src_a_reg,
  input  wire arch_reg_t               src_b_reg,
  // completion requests
  input  wire fu_mask_t                fu_request,
  input  wire phys_reg_t [`NUM_FU-1:0] fu_tag,
  // dispatch results
  output logic                         dispatch_ready,
  output phys_reg_t                    tag_a,
  output phys_reg_t                    tag_b,
  output logic                         ready_a,
  output logic                         ready_b,
  output phys_reg_t                    tag_dest,
  output phys_reg_t                    tag_old,
  // completion
  output fu_mask_t                     fu_grant,
  output logic                         cdb_valid,
  output phys_reg_t                    cdb_tag,
  // retirement
  output logic                         retire_valid,
  output arch_reg_t                    retire_reg,
  output phys_reg_t                    retire_tag,
  output phys_reg_t                    retire_tag_old
);

  logic rob_full;
  logic dispatch_fire;

  ////////////////////////////////////////
  // dispatch handshake
  ////////////////////////////////////////

  // the free list cannot run dry first, so rob space is the only gate
  assign dispatch_ready = ~rob_full;
  assign dispatch_fire  = dispatch_valid & ~rob_full;

  ////////////////////////////////////////
  // blocks
  ////////////////////////////////////////

  map_table u_map_table (
    .clock         (clock),
    .reset         (reset),
    .src_a_reg     (src_a_reg),
    .src_b_reg     (src_b_reg),
    .dest_reg      (dest_reg),
    .dispatch_fire (dispatch_fire),
    .new_tag       (tag_dest),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .tag_a         (tag_a),
    .tag_b         (tag_b),
    .tag_old       (tag_old),
    .ready_a       (ready_a),
    .ready_b       (ready_b)
  );

  // head is the new dest tag, retired old tags return here
  free_list u_free_list (
    .clock    (clock),
    .reset    (reset),
    .pop      (dispatch_fire),
    .push     (retire_valid),
    .push_tag (retire_tag_old),
    .head_tag (tag_dest)
  );

  reorder_buffer u_reorder_buffer (
    .clock          (clock),
    .reset          (reset),
    .dispatch_fire  (dispatch_fire),
    .dest_reg       (dest_reg),
    .new_tag        (tag_dest),
    .old_tag        (tag_old),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .full           (rob_full),
    .retire_valid   (retire_valid),
    .retire_reg     (retire_reg),
    .retire_tag     (retire_tag),
    .retire_tag_old (retire_tag_old)
  );

  complete_select u_complete_select (
    .clock      (clock),
    .reset      (reset),
    .fu_request (fu_request),
    .fu_tag     (fu_tag),
    .fu_grant   (fu_grant),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag)
  );

endmodule

`default_nettype wire

/* tb_rename_core.sv */
// rename core testbench
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module tb_rename_core
  import rename_pkg::*;
();

  localparam int RANDOM_CYCLES = 1200;
  localparam int TAIL_CYCLES   = 100;
  // test needs roughly 1500 cycles
  localparam int CYCLE_LIMIT   = 4000;

  logic                    clock;
  logic                    reset;
  logic                    dispatch_valid;
  arch_reg_t               dest_reg;
  arch_reg_t               src_a_reg;
  arch_reg_t               src_b_reg;
  fu_mask_t                fu_request;
  phys_reg_t [`NUM_FU-1:0] fu_tag;
  logic                    dispatch_ready;
  phys_reg_t               tag_a;
  phys_reg_t               tag_b;
  logic                    ready_a;
  logic                    ready_b;
  phys_reg_t               tag_dest;
  phys_reg_t               tag_old;
  fu_mask_t                fu_grant;
  logic                    cdb_valid;
  phys_reg_t               cdb_tag;
  logic                    retire_valid;
  arch_reg_t               retire_reg;
  phys_reg_t               retire_tag;
  phys_reg_t               retire_tag_old;

  rename_core dut (.*);

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////

  phys_reg_t                model_map [`NUM_ARCH_REG];
  logic [`NUM_PHYS_REG-1:0] model_ready;
  // completion mark, indexed by tag since a tag is in flight once
  logic [`NUM_PHYS_REG-1:0] model_done;
  phys_reg_t                free_q [$];
  arch_reg_t                rob_reg_q [$];
  phys_reg_t                rob_tag_q [$];
  phys_reg_t                rob_old_q [$];
  // broadcast expected in the current cycle
  logic                     exp_cdb_valid = 1'b0;
  phys_reg_t                exp_cdb_tag   = '0;

  // functional units, dispatched tags waiting for a unit
  phys_reg_t                pend_tag [$];
  int                       pend_unit [$];
  logic [`NUM_FU-1:0]       held = '0;
  phys_reg_t                held_tag [`NUM_FU];
  int                       delay_left [`NUM_FU];
  int                       granted_unit = -1;
  logic                     withhold = 1'b0;

  logic [31:0]              lfsr;
  int                       cycle_count = 0;

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // fixed priority, lowest requesting index
  function automatic int lowest_requester(input fu_mask_t mask);
    for (int i = 0; i < `NUM_FU; i++) begin
      if (mask[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  // ready bit with the same-cycle broadcast folded in
  function automatic logic expected_ready(input phys_reg_t tag);
    return model_ready[tag] | (exp_cdb_valid && (exp_cdb_tag == tag));
  endfunction

  // oldest waiting tag owned by a unit
  function automatic int find_pending(input int unit);
    for (int k = 0; k < pend_unit.size(); k++) begin
      if (pend_unit[k] == unit) begin
        return k;
      end
    end
    return -1;
  endfunction

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // mode 0 no dispatch, 1 random dispatch, 2 dispatch every cycle
  task automatic drive_cycle(input int mode);
    fu_mask_t                req;
    phys_reg_t [`NUM_FU-1:0] tags;
    arch_reg_t               d;
    int                      k;
    // unit granted at this edge drops its request
    if (granted_unit >= 0) begin
      held[granted_unit]       = 1'b0;
      delay_left[granted_unit] = int'(rand_bits(2));
    end
    for (int i = 0; i < `NUM_FU; i++) begin
      if (!held[i] && !withhold) begin
        k = find_pending(i);
        if (k >= 0 && delay_left[i] == 0) begin
          held[i]     = 1'b1;
          held_tag[i] = pend_tag[k];
          pend_tag.delete(k);
          pend_unit.delete(k);
        end else if (k >= 0) begin
          delay_left[i]--;
        end
      end
      req[i]  = held[i];
      tags[i] = held_tag[i];
    end
    fu_request <= req;
    fu_tag     <= tags;
    // sources often alias the destination
    d = arch_reg_t'(rand_bits(5));
    dispatch_valid <= (mode == 2) || (mode == 1 && rand_bits(2) != 0);
    dest_reg       <= d;
    src_a_reg      <= rand_bits(1) ? d : arch_reg_t'(rand_bits(5));
    src_b_reg      <= (rand_bits(2) == 0) ? d : arch_reg_t'(rand_bits(5));
  endtask

  // run without dispatch until nothing is in flight
  task automatic drain_rob();
    while (rob_tag_q.size() != 0 || pend_tag.size() != 0) begin
      @(posedge clock);
      drive_cycle(0);
    end
  endtask

  ////////////////////////////////////////
  // checker, mid-cycle
  ////////////////////////////////////////

  always @(negedge clock) begin : check_cycle
    logic      fire;
    logic      retire;
    int        g;
    phys_reg_t new_tag;
    phys_reg_t old_tag;
    if (!reset) begin
      compare_value(dispatch_ready, rob_tag_q.size() < `ROB_SIZE, "dispatch_ready");
      compare_value(cdb_valid, exp_cdb_valid, "cdb_valid");
      if (exp_cdb_valid) begin
        compare_value(cdb_tag, exp_cdb_tag, "cdb_tag");
      end
      // renamed operands
      old_tag = model_map[dest_reg];
      compare_value(tag_a, model_map[src_a_reg], "tag_a");
      compare_value(tag_b, model_map[src_b_reg], "tag_b");
      compare_value(tag_old, old_tag, "tag_old");
      compare_value(tag_dest, free_q[0], "tag_dest");
      compare_value(ready_a, expected_ready(model_map[src_a_reg]), "ready_a");
      compare_value(ready_b, expected_ready(model_map[src_b_reg]), "ready_b");
      g = lowest_requester(fu_request);
      compare_value(fu_grant, (g < 0) ? 0 : (1 << g), "fu_grant");
      // program order retirement
      retire = (rob_tag_q.size() != 0) && model_done[rob_tag_q[0]];
      compare_value(retire_valid, retire, "retire_valid");
      if (retire) begin
        compare_value(retire_reg, rob_reg_q[0], "retire_reg");
        compare_value(retire_tag, rob_tag_q[0], "retire_tag");
        compare_value(retire_tag_old, rob_old_q[0], "retire_tag_old");
      end
      // advance model across the coming edge
      fire = dispatch_valid && (rob_tag_q.size() < `ROB_SIZE);
      if (exp_cdb_valid) begin
        model_ready[exp_cdb_tag] = 1'b1;
        model_done[exp_cdb_tag]  = 1'b1;
      end
      if (retire) begin
        free_q.push_back(rob_old_q.pop_front());
        void'(rob_reg_q.pop_front());
        void'(rob_tag_q.pop_front());
      end
      if (fire) begin
        new_tag              = free_q.pop_front();
        model_map[dest_reg]  = new_tag;
        model_ready[new_tag] = 1'b0;
        model_done[new_tag]  = 1'b0;
        rob_reg_q.push_back(dest_reg);
        rob_tag_q.push_back(new_tag);
        rob_old_q.push_back(old_tag);
        pend_tag.push_back(new_tag);
        pend_unit.push_back(int'(rand_bits(3)) % `NUM_FU);
      end
      // winner shows on the bus next cycle
      granted_unit  = g;
      exp_cdb_valid = (g >= 0);
      if (g >= 0) begin
        exp_cdb_tag = held_tag[g];
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dest_reg       = '0;
    src_a_reg      = '0;
    src_b_reg      = '0;
    fu_request     = '0;
    fu_tag         = '0;
    lfsr           = 32'h2ec6;
    // identity map, upper tags free in order
    for (int r = 0; r < `NUM_ARCH_REG; r++) begin
      model_map[r] = phys_reg_t'(r);
    end
    for (int t = `NUM_ARCH_REG; t < `NUM_PHYS_REG; t++) begin
      free_q.push_back(phys_reg_t'(t));
    end
    for (int i = 0; i < `NUM_FU; i++) begin
      held_tag[i]   = '0;
      delay_left[i] = 0;
    end
    model_ready = '1;
    model_done  = '0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    compare_value(dispatch_ready, 1, "dispatch_ready after reset");
    compare_value(cdb_valid, 0, "cdb_valid after reset");
    compare_value(retire_valid, 0, "retire_valid after reset");
    compare_value(tag_dest, `NUM_ARCH_REG, "first free tag");
    // random traffic
    repeat (RANDOM_CYCLES) begin
      @(posedge clock);
      drive_cycle(1);
    end
    drain_rob();
    // back-pressure with completions held off
    // empty rob takes exactly one buffer's worth before it stalls
    withhold = 1'b1;
    repeat (`ROB_SIZE) begin
      @(posedge clock);
      drive_cycle(2);
    end
    repeat (4) begin
      @(posedge clock);
      drive_cycle(2);
      @(negedge clock);
      compare_value(dispatch_ready, 0, "dispatch_ready while full");
    end
    // release, burst of completions
    withhold = 1'b0;
    repeat (TAIL_CYCLES) begin
      @(posedge clock);
      drive_cycle(1);
    end
    drain_rob();
    repeat (4) begin
      @(posedge clock);
      drive_cycle(0);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
rename_pkg.sv
map_table.sv
free_list.sv
reorder_buffer.sv
complete_select.sv
rename_core.sv
tb_rename_core.sv

/* Makefile */
# Verilator build of the rename core testbench
# any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rename_core
FILELIST  ?= project.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
